// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Shifts take their amount from the low five bits of operand a.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11    // Operand b moved into the upper half.
    } aluc_t;

    // Codes 1, 3 and 4 belong to sources outside the execute stage.
    typedef enum logic [2:0] {
        RD_LO     = 3'd0,
        RD_CLZ    = 3'd2,
        RD_ALU    = 3'd5,
        RD_HI     = 3'd6,
        RD_MUL_LO = 3'd7
    } rd_src_t;

    // A divide puts the remainder in HI and the quotient in LO.
    typedef enum logic [1:0] {
        HL_DIV = 2'd0,
        HL_MUL = 2'd1,
        HL_RS  = 2'd2
    } hilo_src_t;

endpackage

// File: verilog/exec_bus_pkg.sv
package exec_bus_pkg;

    import cpu_isa_pkg::*;

    // One decoded operation as it leaves the decode stage.
    typedef struct packed {
        word_t     rs;
        word_t     rt;
        word_t     immed;           // Already sign or zero extended.
        word_t     shamt;
        logic      alu_a_shamt;
        logic      alu_b_immed;
        aluc_t     aluc;
        logic      muldiv_signed;
        logic      rd_wena;
        reg_addr_t rd_waddr;
        rd_src_t   rd_sel;
        logic      hi_wena;
        hilo_src_t hi_sel;
        logic      lo_wena;
        hilo_src_t lo_sel;
    } exec_uop_t;

    typedef struct packed {
        word_t alu;
        word_t clz;
    } alu_result_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } mul_view_t;

    typedef struct packed {
        word_t rem;
        word_t quo;
    } div_view_t;

    // The multiply/divide unit keeps one word per operation and the select codes
    // decide which view it is read through.
    typedef union packed {
        mul_view_t prod;
        div_view_t div;
    } muldiv_result_u;

    typedef struct packed {
        logic      rd_wena;
        reg_addr_t rd_waddr;
        word_t     rd_data;
        logic      hi_wena;
        word_t     hi_data;
        logic      lo_wena;
        word_t     lo_data;
    } wb_bus_t;

endpackage

// File: verilog/alu_unit.sv
module alu_unit
    import cpu_isa_pkg::*, exec_bus_pkg::*;
(
    input  logic        in_clk,
    input  logic        in_rst,
    input  logic        valid,
    input  exec_uop_t   uop,
    output alu_result_t alu_res
);

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t clz_out;

    assign op_a = uop.alu_a_shamt ? uop.shamt : uop.rs;
    assign op_b = uop.alu_b_immed ? uop.immed : uop.rt;

    always_comb
    begin
        case (uop.aluc)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_NOR:  alu_out = ~(op_a | op_b);
            ALU_SLT:  alu_out = {31'b0, ($signed(op_a) < $signed(op_b))};
            ALU_SLTU: alu_out = {31'b0, (op_a < op_b)};
            ALU_SLL:  alu_out = op_b << op_a[4:0];
            ALU_SRL:  alu_out = op_b >> op_a[4:0];
            ALU_SRA:  alu_out = word_t'($signed(op_b) >>> op_a[4:0]);
            ALU_LUI:  alu_out = {op_b[15:0], 16'b0};
            default:  alu_out = '0;
        endcase
    end

    // The scan runs upward, so the highest set bit decides the count.
    always_comb
    begin
        clz_out = 32'd32;
        for (int i = 0; i < 32; i++)
        begin
            if (uop.rs[i])
                clz_out = 32'(31 - i);
        end
    end

    always_ff @(posedge in_clk)
    begin
        if (valid)
        begin
            alu_res.alu <= alu_out;
            alu_res.clz <= clz_out;
        end
    end

    // Decode never issues an ALU code outside the defined set.
    assert property (@(posedge in_clk) disable iff (in_rst)
        valid |-> uop.aluc inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                                   ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI})
    else
        $error("alu_unit: undefined ALU code %0h", uop.aluc);

endmodule

// File: verilog/muldiv_unit.sv
module muldiv_unit
    import cpu_isa_pkg::*, exec_bus_pkg::*;
(
    input  logic           in_clk,
    input  logic           in_rst,
    input  logic           valid,
    input  exec_uop_t      uop,
    output muldiv_result_u md_res
);

    logic signed [63:0] prod_s;
    logic        [63:0] prod_u;
    word_t              quo;
    word_t              rem;
    logic               keep_prod;
    muldiv_result_u     md_next;

    assign prod_s = $signed(uop.rs) * $signed(uop.rt);
    assign prod_u = uop.rs * uop.rt;

    // Signed division truncates toward zero and the remainder follows rs.
    always_comb
    begin
        if (uop.rt == '0)
        begin
            quo = '1;
            rem = uop.rs;
        end
        else if (uop.muldiv_signed)
        begin
            quo = $signed(uop.rs) / $signed(uop.rt);
            rem = $signed(uop.rs) % $signed(uop.rt);
        end
        else
        begin
            quo = uop.rs / uop.rt;
            rem = uop.rs % uop.rt;
        end
    end

    assign keep_prod = (uop.hi_sel == HL_MUL) || (uop.lo_sel == HL_MUL) ||
                       (uop.rd_sel == RD_MUL_LO);

    always_comb
    begin
        if (keep_prod)
            md_next.prod = uop.muldiv_signed ? prod_s : prod_u;
        else
            md_next.div = '{rem: rem, quo: quo};
    end

    always_ff @(posedge in_clk)
    begin
        if (valid)
            md_res <= md_next;  // Held until the next operation.
    end

    // Only one view survives, so HI and LO must not mix multiply and divide.
    assert property (@(posedge in_clk) disable iff (in_rst)
        valid && uop.hi_wena && uop.lo_wena &&
        (uop.hi_sel inside {HL_DIV, HL_MUL}) && (uop.lo_sel inside {HL_DIV, HL_MUL})
        |-> uop.hi_sel == uop.lo_sel)
    else
        $error("muldiv_unit: HI and LO select both multiply and divide");

endmodule

// File: verilog/writeback_select.sv
module writeback_select
    import cpu_isa_pkg::*, exec_bus_pkg::*;
(
    input  logic           in_clk,
    input  logic           in_rst,
    input  logic           valid,
    input  exec_uop_t      uop,
    input  alu_result_t    alu_res,
    input  muldiv_result_u md_res,
    output logic           wb_valid,
    output wb_bus_t        wb
);

    typedef struct packed {
        logic      rd_wena;
        reg_addr_t rd_waddr;
        rd_src_t   rd_sel;
        logic      hi_wena;
        hilo_src_t hi_sel;
        logic      lo_wena;
        hilo_src_t lo_sel;
    } wb_ctrl_t;

    logic      s1_valid;
    wb_ctrl_t  s1_ctrl;
    word_t     s1_rs;
    word_t     hi_reg;
    word_t     lo_reg;
    word_t     hi_next;
    word_t     lo_next;
    word_t     rd_next;
    logic      rd_wena_q;
    logic      hi_wena_q;
    logic      lo_wena_q;
    reg_addr_t rd_waddr_q;
    word_t     rd_data_q;

    function automatic word_t pick_hilo(hilo_src_t sel, word_t md_w, word_t rs_w, word_t held);
        case (sel)
            HL_DIV,
            HL_MUL:  return md_w;
            HL_RS:   return rs_w;
            default: return held;
        endcase
    endfunction

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            s1_valid <= 1'b0;
            s1_ctrl  <= '0;
        end
        else
        begin
            s1_valid <= valid;
            s1_ctrl  <= '{rd_wena: uop.rd_wena, rd_waddr: uop.rd_waddr, rd_sel: uop.rd_sel,
                          hi_wena: uop.hi_wena, hi_sel: uop.hi_sel,
                          lo_wena: uop.lo_wena, lo_sel: uop.lo_sel};
        end
    end

    always_ff @(posedge in_clk)
    begin
        if (valid)
            s1_rs <= uop.rs;
    end

    // The remainder shares the upper word with the high product, the quotient the lower one.
    assign hi_next = pick_hilo(s1_ctrl.hi_sel, md_res.prod.hi, s1_rs, hi_reg);
    assign lo_next = pick_hilo(s1_ctrl.lo_sel, md_res.prod.lo, s1_rs, lo_reg);

    // HI and LO are read here after the previous operation has already written them.
    always_comb
    begin
        case (s1_ctrl.rd_sel)
            RD_LO:     rd_next = lo_reg;
            RD_CLZ:    rd_next = alu_res.clz;
            RD_ALU:    rd_next = alu_res.alu;
            RD_HI:     rd_next = hi_reg;
            RD_MUL_LO: rd_next = md_res.prod.lo;
            default:   rd_next = '0;
        endcase
    end

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            wb_valid  <= 1'b0;
            rd_wena_q <= 1'b0;
            hi_wena_q <= 1'b0;
            lo_wena_q <= 1'b0;
            hi_reg    <= '0;
            lo_reg    <= '0;
        end
        else
        begin
            wb_valid  <= s1_valid;
            rd_wena_q <= s1_valid && s1_ctrl.rd_wena;
            hi_wena_q <= s1_valid && s1_ctrl.hi_wena;
            lo_wena_q <= s1_valid && s1_ctrl.lo_wena;
            if (s1_valid && s1_ctrl.hi_wena)
                hi_reg <= hi_next;
            if (s1_valid && s1_ctrl.lo_wena)
                lo_reg <= lo_next;
        end
    end

    always_ff @(posedge in_clk)
    begin
        if (s1_valid)
        begin
            rd_waddr_q <= s1_ctrl.rd_waddr;
            rd_data_q  <= rd_next;
        end
    end

    assign wb = '{rd_wena: rd_wena_q, rd_waddr: rd_waddr_q, rd_data: rd_data_q,
                  hi_wena: hi_wena_q, hi_data: hi_reg,       // HI data is the new register value.
                  lo_wena: lo_wena_q, lo_data: lo_reg};

    // An enabled write must name a source that exists in this core.
    assert property (@(posedge in_clk) disable iff (in_rst)
        s1_valid |->
            (!s1_ctrl.rd_wena ||
             s1_ctrl.rd_sel inside {RD_LO, RD_CLZ, RD_ALU, RD_HI, RD_MUL_LO}) &&
            (!s1_ctrl.hi_wena || s1_ctrl.hi_sel inside {HL_DIV, HL_MUL, HL_RS}) &&
            (!s1_ctrl.lo_wena || s1_ctrl.lo_sel inside {HL_DIV, HL_MUL, HL_RS}))
    else
        $error("writeback_select: enabled write with reserved select code");

endmodule

// File: verilog/exec_core.sv
module exec_core
    import exec_bus_pkg::*;
(
    input  logic      in_clk,
    input  logic      in_rst,
    input  logic      valid,
    input  exec_uop_t uop,
    output logic      wb_valid,
    output wb_bus_t   wb
);

    alu_result_t    alu_res;
    muldiv_result_u md_res;

    alu_unit alu_inst (
        .in_clk  (in_clk),
        .in_rst  (in_rst),
        .valid   (valid),
        .uop     (uop),
        .alu_res (alu_res)
    );

    muldiv_unit muldiv_inst (
        .in_clk (in_clk),
        .in_rst (in_rst),
        .valid  (valid),
        .uop    (uop),
        .md_res (md_res)
    );

    // Both unit results land with the stage-1 controls in this block.
    writeback_select wb_inst (
        .in_clk   (in_clk),
        .in_rst   (in_rst),
        .valid    (valid),
        .uop      (uop),
        .alu_res  (alu_res),
        .md_res   (md_res),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

// File: test/exec_vectors.svh
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// Each row is one operation issued in one cycle and the write-back expected for it.
task automatic build_vectors();
    add_op(read_op(RD_HI), rd_write(32'h00000000));    // HI and LO start at zero.
    add_op(read_op(RD_LO), rd_write(32'h00000000));
    add_op(reg_op(ALU_ADD, 32'h7ffffff0, 32'h00000020), rd_write(32'h80000010));
    add_op(reg_op(ALU_SUB, 32'h00000005, 32'h00000007), rd_write(32'hfffffffe));
    add_op(reg_op(ALU_AND, 32'hf0f0ff00, 32'h0ff0f0f0), rd_write(32'h00f0f000));
    add_op(reg_op(ALU_OR, 32'hf0f0ff00, 32'h0ff0f0f0), rd_write(32'hfff0fff0));
    add_op(reg_op(ALU_XOR, 32'hf0f0ff00, 32'h0ff0f0f0), rd_write(32'hff000ff0));
    add_op(reg_op(ALU_NOR, 32'h12340000, 32'h00005678), rd_write(32'hedcba987));
    add_op(reg_op(ALU_SLT, 32'hffffffff, 32'h00000001), rd_write(32'h00000001));
    add_op(reg_op(ALU_SLTU, 32'hffffffff, 32'h00000001), rd_write(32'h00000000));
    add_op(imm_op(ALU_ADD, 32'h00001000, 32'hfffffffc), rd_write(32'h00000ffc));
    add_op(imm_op(ALU_OR, 32'h12340000, 32'h0000abcd), rd_write(32'h1234abcd));
    add_op(imm_op(ALU_SLTU, 32'h00010000, 32'h0000ffff), rd_write(32'h00000000));
    add_op(imm_op(ALU_LUI, 32'h00000000, 32'h0000beef), rd_write(32'hbeef0000));
    add_op(shift_op(ALU_SLL, 32'd4, 32'h8000000f), rd_write(32'h000000f0));
    add_op(shift_op(ALU_SRL, 32'd8, 32'h80001234), rd_write(32'h00800012));
    add_op(shift_op(ALU_SRA, 32'd8, 32'h80001234), rd_write(32'hff800012));
    add_idle();
    add_op(clz_op(32'h00000000), rd_write(32'd32));
    add_op(clz_op(32'h00000001), rd_write(32'd31));
    add_op(clz_op(32'h80000000), rd_write(32'd0));
    // Reads of HI and LO follow right behind the operation that writes them.
    add_op(muldiv_op(HL_MUL, 1'b0, 32'hffffffff, 32'h00000002),
           hilo_write(32'h00000001, 32'hfffffffe));
    add_op(read_op(RD_HI), rd_write(32'h00000001));
    add_op(read_op(RD_LO), rd_write(32'hfffffffe));
    add_op(muldiv_op(HL_MUL, 1'b1, 32'hfffffffd, 32'h00000005),
           hilo_write(32'hffffffff, 32'hfffffff1));
    add_op(read_op(RD_HI), rd_write(32'hffffffff));
    add_op(muldiv_op(HL_DIV, 1'b0, 32'h00000064, 32'h00000007),
           hilo_write(32'h00000002, 32'h0000000e));
    add_op(muldiv_op(HL_DIV, 1'b1, 32'hfffffff9, 32'h00000002),
           hilo_write(32'hffffffff, 32'hfffffffd));
    add_op(muldiv_op(HL_DIV, 1'b0, 32'hfffffff9, 32'h00000002),
           hilo_write(32'h00000001, 32'h7ffffffc));
    add_op(muldiv_op(HL_DIV, 1'b1, 32'h12345678, 32'h00000000),
           hilo_write(32'h12345678, 32'hffffffff));    // Divide by zero.
    add_op(mul_lo_op(32'h00010001, 32'h00010001), rd_write(32'h00020001));
    add_op(move_hi_op(32'hcafef00d), hi_write(32'hcafef00d));
    add_op(read_op(RD_HI), rd_write(32'hcafef00d));
    add_op(read_op(RD_LO), rd_write(32'hffffffff));    // LO still holds the quotient.
    add_idle();
endtask

`endif

// File: test/exec_core_tb.sv
module exec_core_tb
    import cpu_isa_pkg::*, exec_bus_pkg::*;
();

    localparam int DRIVE_DELAY  = 10;
    localparam int SAMPLE_DELAY = 40;
    localparam int WAIT_LIMIT   = 8;

    typedef struct {
        logic      valid;
        exec_uop_t uop;
        wb_bus_t   exp;
    } vec_row_t;

    logic      in_clk;
    logic      in_rst;
    logic      valid;
    exec_uop_t uop;
    logic      wb_valid;
    wb_bus_t   wb;

    vec_row_t rows[$];
    int       issue_cyc[];
    int       cyc = 0;
    int       errors = 0;
    logic     timed_out = 1'b0;

    exec_core dut (
        .in_clk   (in_clk),
        .in_rst   (in_rst),
        .valid    (valid),
        .uop      (uop),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    always #50 in_clk = ~in_clk;

    always @(posedge in_clk)
        cyc <= cyc + 1;

    function automatic exec_uop_t reg_op(aluc_t aluc, word_t rs, word_t rt);
        exec_uop_t u;
        u = '0;
        u.aluc = aluc;
        u.rs = rs;
        u.rt = rt;
        u.rd_wena = 1'b1;
        u.rd_sel = RD_ALU;
        return u;
    endfunction

    // rt is all ones, so taking it instead of the immediate changes the result.
    function automatic exec_uop_t imm_op(aluc_t aluc, word_t rs, word_t immed);
        exec_uop_t u;
        u = reg_op(aluc, rs, '1);
        u.immed = immed;
        u.alu_b_immed = 1'b1;
        return u;
    endfunction

    function automatic exec_uop_t shift_op(aluc_t aluc, word_t shamt, word_t rt);
        exec_uop_t u;
        u = reg_op(aluc, 32'd31, rt);    // A shift by rs would be 31.
        u.shamt = shamt;
        u.alu_a_shamt = 1'b1;
        return u;
    endfunction

    function automatic exec_uop_t clz_op(word_t rs);
        exec_uop_t u;
        u = reg_op(ALU_ADD, rs, 32'h0);
        u.rd_sel = RD_CLZ;
        return u;
    endfunction

    function automatic exec_uop_t read_op(rd_src_t sel);
        exec_uop_t u;
        u = reg_op(ALU_ADD, 32'h0, 32'h0);
        u.rd_sel = sel;
        return u;
    endfunction

    function automatic exec_uop_t mul_lo_op(word_t rs, word_t rt);
        exec_uop_t u;
        u = reg_op(ALU_ADD, rs, rt);
        u.rd_sel = RD_MUL_LO;
        return u;
    endfunction

    function automatic exec_uop_t muldiv_op(hilo_src_t sel, logic sgn, word_t rs, word_t rt);
        exec_uop_t u;
        u = '0;
        u.rs = rs;
        u.rt = rt;
        u.muldiv_signed = sgn;
        u.hi_wena = 1'b1;
        u.hi_sel = sel;
        u.lo_wena = 1'b1;
        u.lo_sel = sel;
        return u;
    endfunction

    function automatic exec_uop_t move_hi_op(word_t rs);
        exec_uop_t u;
        u = '0;
        u.rs = rs;
        u.hi_wena = 1'b1;
        u.hi_sel = HL_RS;
        return u;
    endfunction

    function automatic wb_bus_t rd_write(word_t data);
        wb_bus_t e;
        e = '0;
        e.rd_wena = 1'b1;
        e.rd_data = data;
        return e;
    endfunction

    function automatic wb_bus_t hi_write(word_t hi);
        wb_bus_t e;
        e = '0;
        e.hi_wena = 1'b1;
        e.hi_data = hi;
        return e;
    endfunction

    function automatic wb_bus_t hilo_write(word_t hi, word_t lo);
        wb_bus_t e;
        e = hi_write(hi);
        e.lo_wena = 1'b1;
        e.lo_data = lo;
        return e;
    endfunction

    // The destination register follows the row number and passes straight through.
    task automatic add_op(exec_uop_t u, wb_bus_t e);
        u.rd_waddr = reg_addr_t'(rows.size() % 31 + 1);
        if (e.rd_wena)
            e.rd_waddr = u.rd_waddr;
        rows.push_back('{valid: 1'b1, uop: u, exp: e});
    endtask

    task automatic add_idle();
        rows.push_back('{valid: 1'b0, uop: reg_op(ALU_ADD, 32'h1, 32'h1), exp: '0});
    endtask

    `include "exec_vectors.svh"

    task automatic compare_word(string name, int row, word_t got, word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %s row %0d: got %h, expected %h", name, row, got, exp);
        end
    endtask

    task automatic drive_rows();
        for (int i = 0; i < rows.size(); i++)
        begin
            @(posedge in_clk);
            #DRIVE_DELAY;
            valid = rows[i].valid;
            uop = rows[i].uop;
            issue_cyc[i] = cyc;
        end
        @(posedge in_clk);
        #DRIVE_DELAY;
        valid = 1'b0;
        uop = '0;
    endtask

    task automatic check_rows();
        int waited;
        for (int i = 0; i < rows.size() && !timed_out; i++)
        begin
            if (rows[i].valid)
            begin
                waited = 0;
                do
                begin
                    @(posedge in_clk);
                    #SAMPLE_DELAY;
                    waited++;
                    if (!wb_valid && (wb.rd_wena || wb.hi_wena || wb.lo_wena))
                    begin
                        errors++;
                        $display("A write enable is high without wb_valid at cycle %0d", cyc);
                    end
                end
                while (!wb_valid && waited < WAIT_LIMIT);
                if (!wb_valid)
                begin
                    errors++;
                    timed_out = 1'b1;
                    $display("Timed out waiting for wb_valid of row %0d", i);
                end
                else
                begin
                    if (cyc != issue_cyc[i] + 2)
                    begin
                        errors++;
                        $display("Row %0d came back after %0d cycles instead of 2",
                                 i, cyc - issue_cyc[i]);
                    end
                    compare_word("rd_wena", i, wb.rd_wena, rows[i].exp.rd_wena);
                    compare_word("hi_wena", i, wb.hi_wena, rows[i].exp.hi_wena);
                    compare_word("lo_wena", i, wb.lo_wena, rows[i].exp.lo_wena);
                    if (rows[i].exp.rd_wena)
                    begin
                        compare_word("rd_waddr", i, wb.rd_waddr, rows[i].exp.rd_waddr);
                        compare_word("rd_data", i, wb.rd_data, rows[i].exp.rd_data);
                    end
                    if (rows[i].exp.hi_wena)
                        compare_word("hi_data", i, wb.hi_data, rows[i].exp.hi_data);
                    if (rows[i].exp.lo_wena)
                        compare_word("lo_data", i, wb.lo_data, rows[i].exp.lo_data);
                end
            end
        end
        for (int n = 0; n < 3 && !timed_out; n++)
        begin
            @(posedge in_clk);
            #SAMPLE_DELAY;
            if (wb_valid || wb.rd_wena || wb.hi_wena || wb.lo_wena)
            begin
                errors++;
                $display("Unexpected write-back after the last operation at cycle %0d", cyc);
            end
        end
    endtask

    initial
    begin
        in_clk = 1'b0;
        in_rst = 1'b1;
        valid = 1'b0;
        uop = '0;
        build_vectors();
        issue_cyc = new[rows.size()];
        repeat (2) @(posedge in_clk);
        #DRIVE_DELAY;
        in_rst = 1'b0;
        if (wb_valid || wb.rd_wena || wb.hi_wena || wb.lo_wena)
        begin
            errors++;
            $display("Write-back outputs are not idle after reset");
        end
        fork
            drive_rows();
            check_rows();
        join
        $display("Rows: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+test
verilog/cpu_isa_pkg.sv
verilog/exec_bus_pkg.sv
verilog/alu_unit.sv
verilog/muldiv_unit.sv
verilog/writeback_select.sv
verilog/exec_core.sv
test/exec_core_tb.sv
